// File: files.f
source/eth_pkg.sv
source/mac_rx.sv
source/arp_responder.sv
source/user_frame_buffer.sv
source/mac_tx.sv
source/eth_top.sv
test/eth_tb.sv

// File: source/arp_responder.sv
`timescale 1ns/1ps

module arp_responder (
  input  logic              clk,
  input  logic              rst,
  input  eth_pkg::ipv4_t    ip_addr,
  input  logic              ip_set,
  input  eth_pkg::eth_hdr_t hdr,
  input  logic              hdr_val,
  input  eth_pkg::byte_t    pl_dat,
  input  logic              pl_val,
  input  logic              frame_end,
  input  logic              arp_go,
  output logic              arp_pend,
  output eth_pkg::byte_t    arp_dat,
  output logic              arp_val
);
  import eth_pkg::*;

  arp_state_t state;
  ipv4_t      dev_ip;
  logic       ip_valid;
  logic       is_arp;    // Current frame carries ARP
  logic [4:0] body_cnt;  // ARP body bytes seen
  arp_req_t   req;
  mac_addr_t  peer_mac;  // Requester, held for the reply
  ipv4_t      peer_ip;
  logic [6:0] send_cnt;
  logic [5:0] byte_idx;
  logic [MIN_FRAME_LEN*8-1:0] reply;
  logic       req_ok;

  assign req_ok = is_arp && ip_valid && (body_cnt == 5'(ARP_LEN)) &&
                  (req.oper == ARP_OP_REQ) && (req.tpa == dev_ip);

  //////////////////////////////////////////////////
  // Request capture and reply FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ARP_IDLE;
      ip_valid <= 1'b0;
      is_arp   <= 1'b0;
      body_cnt <= '0;
      send_cnt <= '0;
    end else begin
      if (ip_set) begin
        ip_valid <= 1'b1;
      end
      if (hdr_val) begin
        is_arp   <= (hdr.etype == ETH_ARP);
        body_cnt <= '0;
      end else if (frame_end) begin
        is_arp <= 1'b0;
      end else if (pl_val && body_cnt != 5'(ARP_LEN)) begin
        body_cnt <= body_cnt + 1'b1;
      end
      case (state)
        ARP_IDLE: begin
          if (frame_end && req_ok) begin
            state <= ARP_PEND;
          end
        end
        ARP_PEND: begin
          if (arp_go) begin
            state    <= ARP_SEND;
            send_cnt <= '0;
          end
        end
        ARP_SEND: begin
          send_cnt <= send_cnt + 1'b1;
          if (send_cnt == 7'(PREAMBLE_LEN + MIN_FRAME_LEN - 1)) begin
            state <= ARP_IDLE;
          end
        end
        default: state <= ARP_IDLE;
      endcase
    end
  end

  // Field capture by body offset
  always_ff @(posedge clk) begin
    if (ip_set) begin
      dev_ip <= ip_addr;
    end
    if (pl_val) begin
      if (body_cnt inside {[5'd6:5'd7]}) begin
        req.oper <= {req.oper[7:0], pl_dat};
      end
      if (body_cnt inside {[5'd8:5'd13]}) begin
        req.sha <= {req.sha[39:0], pl_dat};
      end
      if (body_cnt inside {[5'd14:5'd17]}) begin
        req.spa <= {req.spa[23:0], pl_dat};
      end
      if (body_cnt inside {[5'd24:5'd27]}) begin
        req.tpa <= {req.tpa[23:0], pl_dat};
      end
    end
    if (state == ARP_IDLE && frame_end && req_ok) begin
      peer_mac <= req.sha;
      peer_ip  <= req.spa;
    end
  end

  //////////////////////////////////////////////////
  // Reply stream
  //////////////////////////////////////////////////
  assign reply = {peer_mac, DEV_MAC, ETH_ARP,
                  ARP_HTYPE_ETH, ETH_IPV4, 8'd6, 8'd4, ARP_OP_REPLY,
                  DEV_MAC, dev_ip, peer_mac, peer_ip,
                  {(MIN_FRAME_LEN - HDR_LEN - ARP_LEN){8'h00}}}; // Zero pad to 60

  assign arp_pend = (state == ARP_PEND);
  // Bytes start once mac_tx is done with the preamble
  assign arp_val  = (state == ARP_SEND) && (send_cnt >= PREAMBLE_LEN);
  assign byte_idx = arp_val ? 6'(send_cnt - PREAMBLE_LEN) : '0;
  assign arp_dat  = reply[(MIN_FRAME_LEN - 1 - byte_idx)*8 +: 8];

  // First reply byte lines up with the SFD slot after the grant
  reply_after_grant: assert property (@(posedge clk) disable iff (rst)
    $rose(arp_val) |-> $past(arp_go, PREAMBLE_LEN + 1));

endmodule

// File: source/eth_pkg.sv
package eth_pkg;

  //////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [7:0]  byte_t;

  localparam int UFB_DEPTH = 2048; // User frame buffer size in bytes
  localparam int UFB_AW    = 11;

  typedef logic [UFB_AW-1:0] ufb_addr_t; // Byte address in user RAM
  typedef logic [UFB_AW:0]   ufb_len_t;  // Frame length, up to UFB_DEPTH

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////
  localparam mac_addr_t  DEV_MAC   = {8'h42, 8'h55, 8'h92, 8'h16, 8'hEE, 8'h31};
  localparam mac_addr_t  BCAST_MAC = '1;
  localparam ethertype_t ETH_ARP   = 16'h0806;
  localparam ethertype_t ETH_IPV4  = 16'h0800; // ARP protocol type field

  localparam logic [15:0] ARP_HTYPE_ETH = 16'h0001;
  localparam logic [15:0] ARP_OP_REQ    = 16'h0001;
  localparam logic [15:0] ARP_OP_REPLY  = 16'h0002;

  localparam byte_t PRE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE = 8'hD5;

  localparam int PREAMBLE_LEN  = 7;  // 0x55 bytes ahead of the SFD
  localparam int IFG_LEN       = 12; // Idle cycles between frames
  localparam int HDR_LEN       = 14;
  localparam int MIN_FRAME_LEN = 60; // Without FCS
  localparam int ARP_LEN       = 28;

  //////////////////////////////////////////////////
  // Headers
  //////////////////////////////////////////////////
  typedef struct packed {
    mac_addr_t  dst;
    mac_addr_t  src;
    ethertype_t etype;
  } eth_hdr_t;

  // Only the ARP fields the responder needs
  typedef struct packed {
    logic [15:0] oper;
    mac_addr_t   sha;
    ipv4_t       spa;
    ipv4_t       tpa;
  } arp_req_t;

  typedef enum logic [2:0] {RX_IDLE, RX_PRE, RX_HDR, RX_PAYLOAD, RX_DROP} rx_state_t;
  typedef enum logic [1:0] {ARP_IDLE, ARP_PEND, ARP_SEND} arp_state_t;
  typedef enum logic [1:0] {TX_IDLE, TX_PRE, TX_DATA, TX_GAP} tx_state_t;

endpackage

// File: source/eth_top.sv
`timescale 1ns/1ps

module eth_top (
  input  logic           clk,
  input  logic           rst,
  input  eth_pkg::byte_t phy_rx_dat,
  input  logic           phy_rx_val,
  output eth_pkg::byte_t phy_tx_dat,
  output logic           phy_tx_val,
  input  eth_pkg::ipv4_t ip_addr,  // Loaded by ip_set
  input  logic           ip_set,
  input  eth_pkg::byte_t usr_dat,
  input  logic           usr_val,
  input  logic           usr_last,
  output logic           usr_ready,
  output logic           rx_drop
);
  import eth_pkg::*;

  eth_hdr_t hdr;
  logic     hdr_val;
  byte_t    pl_dat;
  logic     pl_val;
  logic     frame_end;
  logic     arp_pend, arp_val, arp_go;
  byte_t    arp_dat;
  logic     usr_pend, uf_val, uf_go;
  byte_t    uf_dat;

  //////////////////////////////////////////////////
  // Receive side
  //////////////////////////////////////////////////
  mac_rx mac_rx_inst (
    .clk        (clk),
    .rst        (rst),
    .phy_rx_dat (phy_rx_dat),
    .phy_rx_val (phy_rx_val),
    .hdr        (hdr),
    .hdr_val    (hdr_val),
    .pl_dat     (pl_dat),
    .pl_val     (pl_val),
    .frame_end  (frame_end),
    .rx_drop    (rx_drop)
  );

  //////////////////////////////////////////////////
  // Frame sources
  //////////////////////////////////////////////////
  arp_responder arp_responder_inst (
    .clk       (clk),
    .rst       (rst),
    .ip_addr   (ip_addr),
    .ip_set    (ip_set),
    .hdr       (hdr),
    .hdr_val   (hdr_val),
    .pl_dat    (pl_dat),
    .pl_val    (pl_val),
    .frame_end (frame_end),
    .arp_go    (arp_go),
    .arp_pend  (arp_pend),
    .arp_dat   (arp_dat),
    .arp_val   (arp_val)
  );

  user_frame_buffer user_frame_buffer_inst (
    .clk       (clk),
    .rst       (rst),
    .usr_dat   (usr_dat),
    .usr_val   (usr_val),
    .usr_last  (usr_last),
    .usr_ready (usr_ready),
    .uf_go     (uf_go),
    .usr_pend  (usr_pend),
    .uf_dat    (uf_dat),
    .uf_val    (uf_val)
  );

  // Transmit side
  mac_tx mac_tx_inst (
    .clk        (clk),
    .rst        (rst),
    .arp_pend   (arp_pend),
    .arp_dat    (arp_dat),
    .arp_val    (arp_val),
    .usr_pend   (usr_pend),
    .uf_dat     (uf_dat),
    .uf_val     (uf_val),
    .arp_go     (arp_go),
    .uf_go      (uf_go),
    .phy_tx_dat (phy_tx_dat),
    .phy_tx_val (phy_tx_val)
  );

endmodule

// File: source/mac_rx.sv
`timescale 1ns/1ps

module mac_rx (
  input  logic              clk,
  input  logic              rst,
  input  eth_pkg::byte_t    phy_rx_dat,
  input  logic              phy_rx_val,
  output eth_pkg::eth_hdr_t hdr,
  output logic              hdr_val,
  output eth_pkg::byte_t    pl_dat,
  output logic              pl_val,
  output logic              frame_end,
  output logic              rx_drop
);
  import eth_pkg::*;

  rx_state_t  state;
  logic [3:0] hdr_cnt;  // Header bytes taken so far
  eth_hdr_t   hdr_next;
  logic       dst_ok;

  // Header shifts in MSB first with dst on top
  assign hdr_next = {hdr[$bits(eth_hdr_t)-9:0], phy_rx_dat};
  assign dst_ok   = (hdr_next.dst == DEV_MAC) || (hdr_next.dst == BCAST_MAC);

  //////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= RX_IDLE;
      hdr_cnt   <= '0;
      hdr_val   <= 1'b0;
      pl_val    <= 1'b0;
      frame_end <= 1'b0;
      rx_drop   <= 1'b0;
    end else begin
      hdr_val   <= 1'b0;
      pl_val    <= 1'b0;
      frame_end <= 1'b0;
      rx_drop   <= 1'b0;
      if (!phy_rx_val) begin
        if (state != RX_IDLE) begin
          frame_end <= 1'b1; // Burst just ended
        end
        state <= RX_IDLE;
      end else begin
        case (state)
          RX_IDLE: begin
            state <= (phy_rx_dat == PRE_BYTE) ? RX_PRE : RX_DROP;
          end
          RX_PRE: begin
            hdr_cnt <= '0;
            if (phy_rx_dat == SFD_BYTE) begin
              state <= RX_HDR;
            end else if (phy_rx_dat != PRE_BYTE) begin
              state <= RX_DROP; // Broken preamble
            end
          end
          RX_HDR: begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt == 4'(HDR_LEN - 1)) begin
              if (dst_ok) begin
                hdr_val <= 1'b1;
                state   <= RX_PAYLOAD;
              end else begin
                rx_drop <= 1'b1; // Foreign unicast
                state   <= RX_DROP;
              end
            end
          end
          RX_PAYLOAD: pl_val <= 1'b1;
          default: ; // Drop waits for the end of the burst
        endcase
      end
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if (state == RX_HDR && phy_rx_val) begin
      hdr <= hdr_next;
    end
    pl_dat <= phy_rx_dat;
  end

  // Header strobe only after the header of an accepted frame
  hdr_val_in_header: assert property (@(posedge clk) disable iff (rst)
    hdr_val |-> $past(state) == RX_HDR && (hdr.dst == DEV_MAC || hdr.dst == BCAST_MAC));

endmodule

// File: source/mac_tx.sv
`timescale 1ns/1ps

module mac_tx (
  input  logic           clk,
  input  logic           rst,
  input  logic           arp_pend,
  input  eth_pkg::byte_t arp_dat,
  input  logic           arp_val,
  input  logic           usr_pend,
  input  eth_pkg::byte_t uf_dat,
  input  logic           uf_val,
  output logic           arp_go,
  output logic           uf_go,
  output eth_pkg::byte_t phy_tx_dat,
  output logic           phy_tx_val
);
  import eth_pkg::*;

  tx_state_t  state;
  logic [3:0] cnt;      // Preamble bytes sent, or gap cycles
  logic       sel_arp;  // Granted source
  byte_t      src_dat;
  logic       src_val;

  //////////////////////////////////////////////////
  // Arbitration, ARP first
  //////////////////////////////////////////////////
  assign arp_go  = (state == TX_IDLE) && arp_pend;
  assign uf_go   = (state == TX_IDLE) && usr_pend && !arp_pend;

  assign src_dat = sel_arp ? arp_dat : uf_dat;
  assign src_val = sel_arp ? arp_val : uf_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= TX_IDLE;
      cnt        <= '0;
      sel_arp    <= 1'b0;
      phy_tx_val <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (arp_go || uf_go) begin
            state      <= TX_PRE;
            sel_arp    <= arp_go;
            cnt        <= 4'd1; // First 0x55 goes out now
            phy_tx_val <= 1'b1;
          end
        end
        TX_PRE: begin
          cnt <= cnt + 1'b1;
          if (cnt == 4'(PREAMBLE_LEN)) begin
            state <= TX_DATA; // SFD goes out now
          end
        end
        TX_DATA: begin
          if (!src_val) begin
            phy_tx_val <= 1'b0;
            state      <= TX_GAP;
            cnt        <= '0;
          end
        end
        TX_GAP: begin
          cnt <= cnt + 1'b1;
          // Idle state adds the last low cycle before the next preamble
          if (cnt == 4'(IFG_LEN - 2)) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Output byte register
  always_ff @(posedge clk) begin
    case (state)
      TX_IDLE: phy_tx_dat <= PRE_BYTE;
      TX_PRE:  phy_tx_dat <= (cnt == 4'(PREAMBLE_LEN)) ? SFD_BYTE : PRE_BYTE;
      default: phy_tx_dat <= src_dat;
    endcase
  end

  // One grant at a time, and the preamble follows it
  single_grant: assert property (@(posedge clk) disable iff (rst)
    (arp_go || uf_go) |-> !(arp_go && uf_go) ##1 (phy_tx_val && phy_tx_dat == PRE_BYTE));

endmodule

// File: source/user_frame_buffer.sv
`timescale 1ns/1ps

module user_frame_buffer (
  input  logic           clk,
  input  logic           rst,
  input  eth_pkg::byte_t usr_dat,
  input  logic           usr_val,
  input  logic           usr_last,
  output logic           usr_ready,
  input  logic           uf_go,
  output logic           usr_pend,
  output eth_pkg::byte_t uf_dat,
  output logic           uf_val
);
  import eth_pkg::*;

  byte_t     mem [UFB_DEPTH];
  byte_t     rd_dat;
  ufb_addr_t wr_ptr;
  ufb_addr_t rd_addr;
  ufb_len_t  frame_len;  // Bytes written by the user
  ufb_len_t  out_len;    // Length after padding
  ufb_len_t  send_cnt;
  ufb_len_t  byte_idx;
  logic      sending;
  logic      wr_en;

  assign wr_en   = usr_val && usr_ready;
  assign out_len = (frame_len < MIN_FRAME_LEN) ? ufb_len_t'(MIN_FRAME_LEN) : frame_len;

  //////////////////////////////////////////////////
  // Write side and replay control
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      usr_ready <= 1'b1;
      usr_pend  <= 1'b0;
      sending   <= 1'b0;
      wr_ptr    <= '0;
      send_cnt  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (usr_last || wr_ptr == ufb_addr_t'(UFB_DEPTH - 1)) begin
          usr_ready <= 1'b0; // Full frame held
          usr_pend  <= 1'b1;
        end
      end
      if (uf_go) begin
        usr_pend <= 1'b0;
        sending  <= 1'b1;
        send_cnt <= '0;
      end else if (sending) begin
        send_cnt <= send_cnt + 1'b1;
        if (send_cnt == out_len + ufb_len_t'(PREAMBLE_LEN - 1)) begin
          sending   <= 1'b0;
          usr_ready <= 1'b1; // Buffer free again
          wr_ptr    <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= usr_dat;
      if (usr_last || wr_ptr == ufb_addr_t'(UFB_DEPTH - 1)) begin
        frame_len <= ufb_len_t'(wr_ptr) + 1'b1;
      end
    end
    rd_dat <= mem[rd_addr];
  end

  // Read one byte ahead to cover the RAM latency
  assign rd_addr  = ufb_addr_t'(send_cnt - ufb_len_t'(PREAMBLE_LEN - 1));
  assign byte_idx = send_cnt - ufb_len_t'(PREAMBLE_LEN);
  assign uf_val   = sending && (send_cnt >= PREAMBLE_LEN);
  assign uf_dat   = (byte_idx < frame_len) ? rd_dat : 8'h00; // Pad short frames

endmodule

// File: test/eth_tb.sv
`timescale 1ns/1ps

module eth_tb;
  import eth_pkg::*;

  localparam int        N_CASES     = 9;
  localparam ipv4_t     DEV_IP      = 32'hC0A8_0A07;
  localparam ipv4_t     OTHER_IP    = 32'hC0A8_0A63;
  localparam mac_addr_t FOREIGN_MAC = 48'h0200_1234_5678;

  typedef enum {K_ARP, K_USER, K_BOTH} kind_t;

  typedef struct {
    kind_t     kind;
    mac_addr_t dst;
    mac_addr_t sha;
    ipv4_t     spa;
    ipv4_t     tpa;
    int        len;     // ARP payload bytes or user frame bytes
    bit        set_ip;
    bit        reply;
  } case_t;

  logic     clk;
  logic     rst;
  byte_t    phy_rx_dat;
  logic     phy_rx_val;
  byte_t    phy_tx_dat;
  logic     phy_tx_val;
  ipv4_t    ip_addr;
  logic     ip_set;
  byte_t    usr_dat;
  logic     usr_val;
  logic     usr_last;
  logic     usr_ready;
  logic     rx_drop;

  case_t cases [N_CASES];
  byte_t usr_bytes [$];
  byte_t exp_q [$];      // Model frames without preamble
  int    exp_len_q [$];
  int    exp_start_q [$];
  byte_t cur_bytes [$];
  byte_t mon_q [$];      // Transmitted frames minus the preamble
  int    mon_len_q [$];
  int    mon_start_q [$];
  int    cyc = 0;
  int    fall_cyc = 0;
  int    last_end = -100;
  int    cur_start = 0;
  int    drop_cnt = 0;
  int    errors = 0;
  int    checks = 0;
  bit    in_frame = 1'b0;

  eth_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin : watchdog
    repeat (N_CASES * 400) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", N_CASES * 400);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      $display("FAILED %s: expected %0h, got %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic mac_addr_t random_mac();
    return {16'($urandom), 32'($urandom)} & ~48'h0100_0000_0000; // Unicast only
  endfunction

  //////////////////////////////////////////////////
  // Transmit monitor
  //////////////////////////////////////////////////
  task automatic take_frame();
    int n;
    int i;
    n = cur_bytes.size();
    checks++;
    assert (n > PREAMBLE_LEN) else begin
      $display("Frame at cycle %0d ended inside the preamble", cur_start);
      errors++;
    end
    if (n > PREAMBLE_LEN) begin
      for (i = 0; i < PREAMBLE_LEN; i++)
        check_val("phy_tx_dat preamble", 8'h55, cur_bytes[i]);
      check_val("phy_tx_dat SFD", 8'hD5, cur_bytes[PREAMBLE_LEN]);
      for (i = PREAMBLE_LEN + 1; i < n; i++)
        mon_q.push_back(cur_bytes[i]);
      mon_len_q.push_back(n - PREAMBLE_LEN - 1);
      mon_start_q.push_back(cur_start);
    end
    cur_bytes.delete();
  endtask

  always @(negedge clk) begin
    if (!rst && rx_drop) drop_cnt++;
    if (!rst && phy_tx_val) begin
      if (!in_frame) begin
        in_frame  = 1'b1;
        cur_start = cyc;
        checks++;
        assert (cyc - last_end >= IFG_LEN) else begin
          $display("Only %0d idle cycles before the frame at cycle %0d", cyc - last_end, cyc);
          errors++;
        end
      end
      cur_bytes.push_back(phy_tx_dat);
    end else if (in_frame) begin
      in_frame = 1'b0;
      last_end = cyc;
      take_frame();
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and model
  //////////////////////////////////////////////////
  task automatic load_table();
    cases[0] = '{K_ARP,  BCAST_MAC,   random_mac(), $urandom, DEV_IP,   46,  1'b0, 1'b0};
    cases[1] = '{K_ARP,  BCAST_MAC,   random_mac(), $urandom, OTHER_IP, 46,  1'b1, 1'b0};
    cases[2] = '{K_ARP,  BCAST_MAC,   random_mac(), $urandom, DEV_IP,   46,  1'b0, 1'b1};
    cases[3] = '{K_ARP,  FOREIGN_MAC, random_mac(), $urandom, DEV_IP,   46,  1'b0, 1'b0};
    cases[4] = '{K_ARP,  DEV_MAC,     random_mac(), $urandom, DEV_IP,   46,  1'b0, 1'b1};
    cases[5] = '{K_USER, '0,          '0,           '0,       '0,       20,  1'b0, 1'b1};
    cases[6] = '{K_USER, '0,          '0,           '0,       '0,       100, 1'b0, 1'b1};
    cases[7] = '{K_BOTH, BCAST_MAC,   random_mac(), $urandom, DEV_IP,   33,  1'b0, 1'b1};
    cases[8] = '{K_USER, '0,          '0,           '0,       '0,       60,  1'b0, 1'b1};
  endtask

  task automatic drive_rx(input byte_t b);
    phy_rx_val = 1'b1;
    phy_rx_dat = b;
    next_cycle();
  endtask

  task automatic send_arp(input case_t c);
    logic [335:0] f;
    int i;
    f = {c.dst, c.sha, 16'h0806, 16'h0001, 16'h0800, 8'd6, 8'd4, 16'h0001,
         c.sha, c.spa, 48'h0, c.tpa};
    for (i = 0; i < PREAMBLE_LEN; i++) drive_rx(8'h55);
    drive_rx(8'hD5);
    for (i = 0; i < 42; i++) drive_rx(f[(41 - i)*8 +: 8]);
    for (i = 42; i < 14 + c.len; i++) drive_rx(8'h00); // Request padding
    phy_rx_val = 1'b0;
    fall_cyc   = cyc;
  endtask

  task automatic drive_user(input int first, input int last_idx, input bit mark_last);
    int i;
    for (i = first; i <= last_idx; i++) begin
      usr_val  = 1'b1;
      usr_dat  = usr_bytes[i];
      usr_last = mark_last && (i == last_idx);
      next_cycle();
    end
    usr_val  = 1'b0;
    usr_last = 1'b0;
  endtask

  task automatic expect_reply(input case_t c);
    logic [335:0] f;
    int i;
    f = {c.sha, DEV_MAC, 16'h0806, 16'h0001, 16'h0800, 8'd6, 8'd4, 16'h0002,
         DEV_MAC, DEV_IP, c.sha, c.spa};
    for (i = 0; i < 42; i++) exp_q.push_back(f[(41 - i)*8 +: 8]);
    for (i = 42; i < 60; i++) exp_q.push_back(8'h00);
    exp_len_q.push_back(60);
    exp_start_q.push_back(fall_cyc + 3); // Idle transmitter
  endtask

  task automatic expect_user(input int len);
    int i;
    for (i = 0; i < len; i++) exp_q.push_back(usr_bytes[i]);
    for (i = len; i < 60; i++) exp_q.push_back(8'h00);
    exp_len_q.push_back(len < 60 ? 60 : len);
    exp_start_q.push_back(-1);
  endtask

  task automatic compare_frames(input int idx);
    int got;
    int want;
    int f;
    int i;
    int ebase;
    int mbase;
    got   = mon_len_q.size();
    want  = exp_len_q.size();
    ebase = 0;
    mbase = 0;
    checks++;
    assert (got == want) else begin
      $display("Case %0d expected %0d transmitted frame(s) but saw %0d", idx, want, got);
      errors++;
    end
    for (f = 0; f < want && f < got; f++) begin
      check_val("frame length", exp_len_q[f], mon_len_q[f]);
      for (i = 0; i < exp_len_q[f] && i < mon_len_q[f]; i++)
        check_val($sformatf("phy_tx_dat[%0d]", i), exp_q[ebase + i], mon_q[mbase + i]);
      if (exp_start_q[f] >= 0)
        check_val("phy_tx_val rise cycle", exp_start_q[f], mon_start_q[f]);
      ebase += exp_len_q[f];
      mbase += mon_len_q[f];
    end
    exp_q.delete();
    exp_len_q.delete();
    exp_start_q.delete();
    mon_q.delete();
    mon_len_q.delete();
    mon_start_q.delete();
  endtask

  task automatic run_case(input int idx);
    case_t c;
    int    drops;
    int    t;
    int    i;
    bit    foreign;
    c       = cases[idx];
    drops   = drop_cnt;
    foreign = (c.kind != K_USER) && (c.dst != DEV_MAC) && (c.dst != BCAST_MAC);
    if (c.set_ip) begin
      ip_addr = DEV_IP;
      ip_set  = 1'b1;
      next_cycle();
      ip_set  = 1'b0;
    end
    if (c.kind != K_ARP) begin
      usr_bytes.delete();
      for (i = 0; i < c.len; i++) usr_bytes.push_back(8'($urandom));
      check_val("usr_ready", 1, usr_ready);
    end
    case (c.kind)
      K_ARP: begin
        send_arp(c);
        if (c.reply) expect_reply(c);
      end
      K_USER: begin
        drive_user(0, c.len - 1, 1'b1);
        expect_user(c.len);
      end
      default: begin
        // Last user byte lands with the ARP pend and both wait together
        drive_user(0, c.len - 2, 1'b0);
        send_arp(c);
        next_cycle();
        drive_user(c.len - 1, c.len - 1, 1'b1);
        expect_reply(c);
        expect_user(c.len);
      end
    endcase
    if (c.kind != K_ARP) check_val("usr_ready", 0, usr_ready);
    for (t = 0; t < 200 && mon_len_q.size() < exp_len_q.size(); t++) next_cycle();
    // Long enough for a stray frame to finish
    repeat (PREAMBLE_LEN + 1 + MIN_FRAME_LEN + IFG_LEN + 8) next_cycle();
    compare_frames(idx);
    check_val("rx_drop pulses", foreign ? 1 : 0, drop_cnt - drops);
    check_val("usr_ready", 1, usr_ready);
  endtask

  initial begin
    int i;
    void'($urandom(32'h79666cf1));
    rst        = 1'b1;
    phy_rx_dat = '0;
    phy_rx_val = 1'b0;
    ip_addr    = '0;
    ip_set     = 1'b0;
    usr_dat    = '0;
    usr_val    = 1'b0;
    usr_last   = 1'b0;
    load_table();
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    check_val("phy_tx_val", 0, phy_tx_val);
    check_val("usr_ready", 1, usr_ready);
    check_val("rx_drop", 0, rx_drop);
    next_cycle();
    for (i = 0; i < N_CASES; i++) run_case(i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
